//--- src/drawPkg.sv
`default_nettype none

package drawPkg;

	////////////////////
	// Geometry
	////////////////////

	localparam int colWidth = 7;   // 128 columns
	localparam int rowWidth = 5;   // 32 rows
	localparam int pixWidth = 3;   // {R, G, B}

	// Control code that requests a bank swap
	localparam logic [14:0] swapCode = 15'h7fff;

	////////////////////
	// Command word
	////////////////////

	// One 16-bit word, read either as span data or as a control code
	typedef union packed
	{
		struct packed
		{
			logic                isCtrl;  // Clear for span words
			logic [rowWidth-1:0] row;
			logic [pixWidth-1:0] color;
			logic [colWidth-1:0] col;     // First col, or last col in an end word
		} spanView;
		struct packed
		{
			logic        isCtrl;
			logic [14:0] code;
		} ctrlView;
	} cmdWord_t;

	////////////////////
	// Pixel paths
	////////////////////

	// Back bank write, one pixel
	typedef struct packed
	{
		logic                en;
		logic [rowWidth-1:0] row;
		logic [colWidth-1:0] col;
		logic [pixWidth-1:0] color;
	} pixWrite_t;

	// Front bank read request from the scanner
	typedef struct packed
	{
		logic [rowWidth-1:0] row;
		logic [colWidth-1:0] col;
		logic                visible;  // Inside the active area
	} scanPos_t;

endpackage

`default_nettype wire

//--- src/cmdQueue.sv
`default_nettype none

module cmdQueue #(
	parameter int queueDepth = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              inValid,
	input  drawPkg::cmdWord_t inWord,
	input  logic              outReady,
	output logic              outValid,
	output drawPkg::cmdWord_t outWord,
	output logic              credit
);
	import drawPkg::*;

	localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntWidth = $clog2(queueDepth + 1);

	cmdWord_t            mem [queueDepth];  // Word storage
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;             // Occupancy
	logic                full;
	logic                push;
	logic                pop;

	// Circular wrap, depth need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
		return (p == ptrWidth'(queueDepth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full     = (count == cntWidth'(queueDepth));
	assign push     = inValid && !full;       // Overflow word is dropped
	assign pop      = outValid && outReady;
	assign outValid = (count != '0);
	assign outWord  = mem[rdPtr];             // Head word, visible the cycle after write

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= inWord;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			count  <= count + cntWidth'(push) - cntWidth'(pop);
			credit <= pop;  // One credit back per word handed on
		end
	end

	// Source must respect its credits
	noOverflow: assert property (@(posedge clk) disable iff (!reset) inValid |-> !full);

endmodule

`default_nettype wire

//--- src/spanRaster.sv
`default_nettype none

module spanRaster (
	input  logic               clk,
	input  logic               reset,
	input  logic               inValid,
	input  drawPkg::cmdWord_t  inWord,
	input  logic               frameStart,
	output logic               inReady,
	output drawPkg::pixWrite_t pix,
	output logic               swapReq
);
	import drawPkg::*;

	enum logic [1:0] {idle, haveStart, drawing, waitSwap} state;

	logic [rowWidth-1:0] spanRow;    // Latched from start word
	logic [pixWidth-1:0] spanColor;
	logic [colWidth-1:0] curCol;     // First col, then the walking col
	logic [colWidth-1:0] lastCol;    // From end word
	logic                take;
	logic                isSwap;
	logic                isSpan;

	assign take   = inValid && inReady;
	assign isSwap = inWord.ctrlView.isCtrl && (inWord.ctrlView.code == swapCode);
	assign isSpan = !inWord.spanView.isCtrl;

	// Words only taken between spans
	assign inReady = (state == idle) || (state == haveStart);
	assign swapReq = (state == waitSwap);  // Held until frameStart

	always_comb
	begin
		pix.en    = (state == drawing);
		pix.row   = spanRow;
		pix.col   = curCol;
		pix.color = spanColor;
	end

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!reset)
			state <= idle;
		else
		begin
			case (state)
				idle:
				begin
					if (take && isSwap)
						state <= waitSwap;
					else if (take && isSpan)
						state <= haveStart;  // Other control codes ignored
				end
				haveStart:
				begin
					// Reversed span drops out, nothing written
					if (take)
						state <= (inWord.spanView.col < curCol) ? idle : drawing;
				end
				drawing:
				begin
					if (curCol == lastCol)
						state <= idle;
				end
				waitSwap:
				begin
					if (frameStart)
						state <= idle;  // Frame buffer flips on this same edge
				end
			endcase
		end
	end

	////////////////////
	// Span payload
	////////////////////

	always_ff @(posedge clk)
	begin
		if (state == idle && take && isSpan)
		begin
			spanRow   <= inWord.spanView.row;
			spanColor <= inWord.spanView.color;
			curCol    <= inWord.spanView.col;
		end
		if (state == haveStart && take)
			lastCol <= inWord.spanView.col;  // End word, col only
		if (state == drawing)
			curCol <= curCol + 1'b1;           // One pixel per clock
	end

	noWriteInSwap: assert property (@(posedge clk) disable iff (!reset) swapReq |-> !pix.en);

endmodule

`default_nettype wire

//--- src/frameBuffer.sv
`default_nettype none

module frameBuffer (
	input  logic                         clk,
	input  logic                         reset,
	input  drawPkg::pixWrite_t           pix,
	input  drawPkg::scanPos_t            pos,
	input  logic                         swap,
	output logic [drawPkg::pixWidth-1:0] color,
	output logic                         presented
);
	import drawPkg::*;

	localparam int addrWidth = rowWidth + colWidth;
	localparam int bankSize  = 1 << addrWidth;   // 4096 pixels

	logic [pixWidth-1:0]  bank0 [bankSize];
	logic [pixWidth-1:0]  bank1 [bankSize];
	logic                 frontSel;   // Bank being shown
	logic                 readSel;
	logic [addrWidth-1:0] wrAddr;
	logic [addrWidth-1:0] rdAddr;
	logic                 showing;

	assign wrAddr  = {pix.row, pix.col};  // Row-major
	assign rdAddr  = {pos.row, pos.col};
	assign readSel = frontSel ^ swap;     // New front already read on the swap cycle
	assign showing = pos.visible && (presented || swap);

	// Writes always land in the back bank
	always_ff @(posedge clk)
	begin
		if (pix.en && frontSel)
			bank0[wrAddr] <= pix.color;
	end

	always_ff @(posedge clk)
	begin
		if (pix.en && !frontSel)
			bank1[wrAddr] <= pix.color;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			frontSel  <= 1'b0;
			presented <= 1'b0;
			color     <= '0;
		end
		else
		begin
			if (swap)
			begin
				frontSel  <= ~frontSel;
				presented <= 1'b1;  // Black until first swap
			end
			color <= showing ? (readSel ? bank1[rdAddr] : bank0[rdAddr]) : '0;
		end
	end

endmodule

`default_nettype wire

//--- src/vgaScan.sv
`default_nettype none

module vgaScan #(
	parameter int hVisible = 128,
	parameter int hFront   = 4,
	parameter int hSync    = 8,
	parameter int hBack    = 4,
	parameter int vVisible = 32,
	parameter int vFront   = 1,
	parameter int vSync    = 2,
	parameter int vBack    = 1
) (
	input  logic              clk,
	input  logic              reset,
	output drawPkg::scanPos_t pos,
	output logic              frameStart,
	output logic              hsync,
	output logic              vsync
);
	import drawPkg::*;

	localparam int hTotal     = hVisible + hFront + hSync + hBack;  // Clocks per line
	localparam int vTotal     = vVisible + vFront + vSync + vBack;  // Lines per frame
	localparam int hSyncStart = hVisible + hFront;
	localparam int vSyncStart = vVisible + vFront;
	localparam int hWidth     = $clog2(hTotal);
	localparam int vWidth     = $clog2(vTotal);

	logic [hWidth-1:0] hCount;   // Pixel in line
	logic [vWidth-1:0] vCount;   // Line in frame
	logic              lineEnd;
	logic              hSyncNow;
	logic              vSyncNow;

	assign lineEnd  = (hCount == hWidth'(hTotal - 1));
	assign hSyncNow = (hCount >= hWidth'(hSyncStart)) && (hCount < hWidth'(hSyncStart + hSync));
	assign vSyncNow = (vCount >= vWidth'(vSyncStart)) && (vCount < vWidth'(vSyncStart + vSync));

	// Read request for this cycle, color comes back next cycle
	always_comb
	begin
		pos.row     = vCount[rowWidth-1:0];
		pos.col     = hCount[colWidth-1:0];
		pos.visible = (hCount < hWidth'(hVisible)) && (vCount < vWidth'(vVisible));
	end

	assign frameStart = (hCount == '0) && (vCount == '0);  // First pixel of line 0

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			vCount <= (vCount == vWidth'(vTotal - 1)) ? '0 : vCount + 1'b1;
		end
		else
			hCount <= hCount + 1'b1;
	end

	// Syncs delayed one clock, in step with the registered color
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			hsync <= !hSyncNow;  // Active low
			vsync <= !vSyncNow;
		end
	end

	countersInRange: assert property (@(posedge clk) disable iff (!reset)
		hCount < hWidth'(hTotal) && vCount < vWidth'(vTotal));

endmodule

`default_nettype wire

//--- src/drawTop.sv
`default_nettype none

module drawTop #(
	parameter int queueDepth = 8,
	parameter int hVisible   = 128,
	parameter int hFront     = 4,
	parameter int hSync      = 8,
	parameter int hBack      = 4,
	parameter int vVisible   = 32,
	parameter int vFront     = 1,
	parameter int vSync      = 2,
	parameter int vBack      = 1
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         cmdValid,
	input  drawPkg::cmdWord_t            cmdWord,
	output logic                         cmdCredit,
	output logic [drawPkg::pixWidth-1:0] color,  // {R, G, B}
	output logic                         hsync,
	output logic                         vsync
);
	import drawPkg::*;

	cmdWord_t  queueWord;
	logic      queueValid;
	logic      rasterReady;
	pixWrite_t pix;          // Raster to back bank
	scanPos_t  pos;          // Scanner to front bank
	logic      swapReq;
	logic      frameStart;
	logic      swap;

	assign swap = swapReq && frameStart;  // Flip only at a frame boundary

	cmdQueue #(.queueDepth(queueDepth)) queue_i (
		.clk(clk), .reset(reset),
		.inValid(cmdValid), .inWord(cmdWord),
		.outReady(rasterReady), .outValid(queueValid), .outWord(queueWord),
		.credit(cmdCredit)
	);

	spanRaster raster_i (
		.clk(clk), .reset(reset),
		.inValid(queueValid), .inWord(queueWord), .frameStart(frameStart),
		.inReady(rasterReady), .pix(pix), .swapReq(swapReq)
	);

	frameBuffer frameBuffer_i (
		.clk(clk), .reset(reset),
		.pix(pix), .pos(pos), .swap(swap),
		.color(color), .presented()
	);

	vgaScan #(
		.hVisible(hVisible), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vVisible(vVisible), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) scan_i (
		.clk(clk), .reset(reset),
		.pos(pos), .frameStart(frameStart), .hsync(hsync), .vsync(vsync)
	);

endmodule

`default_nettype wire

//--- test/drawCheck.sv
`default_nettype none

module drawCheck #(
	parameter int hVisible = 128,
	parameter int hFront   = 4,
	parameter int hSync    = 8,
	parameter int hBack    = 4,
	parameter int vVisible = 32,
	parameter int vFront   = 1,
	parameter int vSync    = 2,
	parameter int vBack    = 1
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        cmdValid,
	input  logic [15:0] cmdWord,
	input  logic        cmdCredit,
	input  logic [2:0]  color,
	input  logic        hsync,
	input  logic        vsync,
	input  int          checkId,
	input  int          checkAt,     // Frame count that ends the checked frame
	output int          frameCount,
	output int          doneId,
	output int          passed,
	output int          failed
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int hTotal   = hVisible + hFront + hSync + hBack;
	localparam int vTotal   = vVisible + vFront + vSync + vBack;
	localparam int hSyncEnd = hVisible + hFront + hSync;  // First clock after hsync pulse
	localparam int vSyncEnd = vVisible + vFront + vSync;

	int    model [2][vVisible][hVisible];  // -1 where never painted
	int    frontIdx;
	bit    presented;                      // Model has seen a swap
	bit    haveStart;
	int    startRow;
	int    startCol;
	int    startColor;
	int    words;                          // Words seen at the DUT input
	int    credits;                        // cmdCredit pulses seen
	int    cycle;
	int    lastHFall;
	int    lastVFall;
	int    vPeriods;
	int    syncErrs;
	int    mismatches;
	int    hPos;                           // Output-side scan position
	int    vLine;
	bit    synced;
	logic  prevH;
	logic  prevV;
	string names [1:7];

	initial
	begin
		names[1] = "sync after reset";
		names[2] = "black before first swap";
		names[3] = "spans shown after swap";
		names[4] = "back drawing hidden";
		names[5] = "swap shows back image";
		names[6] = "second swap restores";
		names[7] = "random span flood";
	end

	////////////////////
	// Reference model
	////////////////////

	// Paints one span into the back image; reversed spans paint nothing
	function automatic void paintSpan(input int row, input int first, input int last, input int c);
		for (int col = first; col <= last; col++)
			model[1 - frontIdx][row][col] = c;
	endfunction

	// Black until the first swap, then the front image
	function automatic int expectedPixel(input int row, input int col);
		return presented ? model[frontIdx][row][col] : 0;
	endfunction

	function automatic void syncFail(input string what, input int got, input int want);
		syncErrs++;
		$display("Fail at %0t ns: %s %0d cycles, expected %0d", $time, what, got, want);
	endfunction

	// Closes one check, returns the number of problems found
	function automatic int report();
		int bad;
		bad = mismatches + syncErrs;
		if (credits != words)
		begin
			bad++;
			$display("Credit pulses %0d do not match %0d words sent", credits, words);
		end
		if (vPeriods == 0)
		begin
			bad++;
			$display("No full vsync period was seen before the check");
		end
		$display("Test %0d %s: %s, %0d pixel mismatches, %0d sync errors", checkId,
			names[checkId], (bad == 0) ? "ok" : "failed", mismatches, syncErrs);
		mismatches = 0;
		syncErrs   = 0;
		return bad;
	endfunction

	////////////////////
	// Monitor
	////////////////////

	always @(posedge clk)
	begin
		int  want;
		bit  checking;
		if (!reset)
		begin
			for (int b = 0; b < 2; b++)
				for (int r = 0; r < vVisible; r++)
					for (int c = 0; c < hVisible; c++)
						model[b][r][c] = -1;
			frontIdx   = 0;
			presented  = 0;
			haveStart  = 0;
			words      = 0;
			credits    = 0;
			cycle      = 0;
			lastHFall  = 0;
			lastVFall  = 0;
			vPeriods   = 0;
			syncErrs   = 0;
			mismatches = 0;
			hPos       = 0;
			vLine      = 0;
			synced     = 0;
			frameCount <= 0;
			doneId     <= 0;
			passed     <= 0;
			failed     <= 0;
		end
		else
		begin
			cycle++;
			// Sync pulse widths and periods
			if (prevH && !hsync)
			begin
				if (lastHFall > 0 && cycle - lastHFall != hTotal)
					syncFail("hsync period", cycle - lastHFall, hTotal);
				lastHFall = cycle;
			end
			if (!prevH && hsync && cycle - lastHFall != hSync)
				syncFail("hsync low", cycle - lastHFall, hSync);
			if (prevV && !vsync)
			begin
				if (lastVFall > 0)
				begin
					vPeriods++;
					if (cycle - lastVFall != hTotal * vTotal)
						syncFail("vsync period", cycle - lastVFall, hTotal * vTotal);
				end
				lastVFall = cycle;
			end
			if (!prevV && vsync && cycle - lastVFall != hTotal * vSync)
				syncFail("vsync low", cycle - lastVFall, hTotal * vSync);

			// Position recovered from the sync edges
			if (!prevH && hsync)
				hPos = hSyncEnd;
			else
			begin
				hPos = (hPos + 1) % hTotal;
				if (hPos == 0)
					vLine = (vLine + 1) % vTotal;
			end
			if (!prevV && vsync)
			begin
				vLine  = vSyncEnd;
				synced = 1;
			end

			checking = (checkAt > 0) && (frameCount == checkAt - 1);
			if (synced && checking && hPos < hVisible && vLine < vVisible)
			begin
				want = expectedPixel(vLine, hPos);
				if (want >= 0 && int'(color) != want)
				begin
					mismatches++;
					if (mismatches <= 4)
						$display("Fail at %0t ns: row %0d col %0d shows %0d, expected %0d",
							$time, vLine, hPos, color, want);
				end
			end
			if (synced && hPos == hVisible - 1 && vLine == vVisible - 1)
			begin
				frameCount <= frameCount + 1;  // Last visible pixel of a frame
				if (checking)
				begin
					if (report() == 0)
						passed <= passed + 1;
					else
						failed <= failed + 1;
					doneId <= checkId;
				end
			end

			// Command decode, bit fields straight from the word layout
			if (cmdCredit)
				credits++;
			if (cmdValid)
			begin
				words++;
				if (haveStart)
				begin
					paintSpan(startRow, startCol, int'(cmdWord[6:0]), startColor);
					haveStart = 0;
				end
				else if (cmdWord[15])
				begin
					if (cmdWord[14:0] == 15'h7fff)
					begin
						frontIdx  = 1 - frontIdx;  // Images trade places
						presented = 1;
					end
				end
				else
				begin
					haveStart  = 1;
					startRow   = int'(cmdWord[14:10]);
					startColor = int'(cmdWord[9:7]);
					startCol   = int'(cmdWord[6:0]);
				end
			end
		end
		prevH = hsync;
		prevV = vsync;
	end

endmodule

`default_nettype wire

//--- test/drawTb.sv
`default_nettype none

module drawTb;
	timeunit 1ns;
	timeprecision 100ps;
	import drawPkg::*;

	localparam int queueDepth  = 8;
	localparam int hVisible    = 128;
	localparam int hFront      = 4;
	localparam int hSync       = 8;
	localparam int hBack       = 4;
	localparam int vVisible    = 32;
	localparam int vFront      = 1;
	localparam int vSync       = 2;
	localparam int vBack       = 1;
	localparam int frameCycles = (hVisible + hFront + hSync + hBack)
		* (vVisible + vFront + vSync + vBack);
	localparam int numTests    = 7;
	localparam int floodSpans  = 200;

	logic                clk;
	logic                reset;
	logic                cmdValid;
	cmdWord_t            cmdWord;
	logic                cmdCredit;
	logic [pixWidth-1:0] color;
	logic                hsync;
	logic                vsync;
	int                  checkId;
	int                  checkAt;
	int                  frameCount;
	int                  doneId;
	int                  passed;
	int                  failed;
	int                  sent;        // Words pushed by the source
	int                  returned;    // Credits received
	int                  sourceErrs;
	logic [31:0]         lcgState = 32'd35;

	drawTop #(
		.queueDepth(queueDepth),
		.hVisible(hVisible), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vVisible(vVisible), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) drawTop_i (
		.clk(clk), .reset(reset), .cmdValid(cmdValid), .cmdWord(cmdWord),
		.cmdCredit(cmdCredit), .color(color), .hsync(hsync), .vsync(vsync)
	);

	drawCheck #(
		.hVisible(hVisible), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vVisible(vVisible), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) check_i (
		.clk(clk), .reset(reset), .cmdValid(cmdValid), .cmdWord(cmdWord),
		.cmdCredit(cmdCredit), .color(color), .hsync(hsync), .vsync(vsync),
		.checkId(checkId), .checkAt(checkAt), .frameCount(frameCount),
		.doneId(doneId), .passed(passed), .failed(failed)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 25 MHz
	end

	// Credits come back one per popped word
	always @(posedge clk)
	begin
		if (cmdCredit)
		begin
			returned++;
			if (returned > sent)
			begin
				sourceErrs++;
				$display("Credit returned at %0t ns with no word outstanding", $time);
			end
		end
	end

	function automatic int nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'(lcgState[30:16]);
	endfunction

	////////////////////
	// Source tasks
	////////////////////

	task automatic sendWord(input logic [15:0] w);
		while (queueDepth - sent + returned <= 0)
			@(negedge clk);  // Out of credits
		cmdValid = 1'b1;
		cmdWord  = w;
		sent++;
		@(negedge clk);
		cmdValid = 1'b0;
	endtask

	task automatic sendSpan(input int row, input int first, input int last, input int c);
		sendWord({1'b0, 5'(row), 3'(c), 7'(first)});
		sendWord({9'b0, 7'(last)});  // End word, col only
	endtask

	task automatic sendSwap();
		sendWord(16'hffff);
	endtask

	task automatic drainQueue();
		while (returned != sent)
			@(negedge clk);
	endtask

	// Compares the second full frame from now
	task automatic runCheck(input int id);
		drainQueue();
		checkId = id;
		checkAt = frameCount + 2;
		while (doneId != id)
			@(negedge clk);
	endtask

	////////////////////
	// Tests
	////////////////////

	initial
	begin
		int row;
		int first;
		int last;
		int c;
		cmdValid   = 1'b0;
		cmdWord    = '0;
		reset      = 1'b0;
		checkId    = 0;
		checkAt    = 0;
		sent       = 0;
		returned   = 0;
		sourceErrs = 0;
		repeat (16) @(negedge clk);
		reset = 1'b1;
		repeat (2 * frameCycles) @(negedge clk);  // Room for full sync periods
		runCheck(1);
		for (int r = 0; r < vVisible; r++)
			sendSpan(r, 0, hVisible - 1, r % 7 + 1);  // Fill whole back bank
		runCheck(2);
		sendSpan(3, 10, 40, 3);
		sendSpan(5, 64, 64, 2);    // Single pixel
		sendSpan(7, 90, 20, 5);    // Reversed, draws nothing
		sendSpan(31, 0, 127, 0);
		sendSpan(0, 127, 127, 7);
		sendSwap();
		runCheck(3);
		sendSpan(12, 0, 127, 2);
		sendSpan(3, 30, 35, 5);
		runCheck(4);
		sendSwap();
		runCheck(5);
		sendSwap();
		runCheck(6);
		for (int i = 0; i < floodSpans; i++)
		begin
			row   = nextRand() % vVisible;
			first = nextRand() % hVisible;
			last  = nextRand() % hVisible;
			c     = nextRand() % 8;
			sendSpan(row, first, last, c);
		end
		drainQueue();
		sendSwap();
		runCheck(7);
		$display("Tests passed %0d, failed %0d, source errors %0d", passed, failed, sourceErrs);
		if (failed == 0 && sourceErrs == 0 && passed == numTests)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Each test needs at most about four frames
	initial
	begin
		repeat (16 + (numTests * 4 + 2) * frameCycles) @(posedge clk);
		$display("Timeout: the tests did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/drawPkg.sv
src/cmdQueue.sv
src/spanRaster.sv
src/frameBuffer.sv
src/vgaScan.sv
src/drawTop.sv
test/drawCheck.sv
test/drawTb.sv

//--- run.sh
#!/bin/sh
# Build and run the span renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module drawTb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VdrawTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^=== PASS ===$"; then
	exit 0
fi
exit 1
